//--- hw/pwm_meas_pkg.sv
// definitions shared by the measurement side of the design.
package pwm_meas_pkg;

	// counter width used when the top level does not override CNT_W.
	localparam int CNT_W_DEFAULT = 32;

	// states of the period meter.
	// WAIT_RISE holds until the first rising strobe after enable or an abort.
	// MEAS_HIGH counts the high phase and MEAS_LOW counts the rest of the period.
	typedef enum logic [1:0] {
		WAIT_RISE = 2'd0, // no period open yet.
		MEAS_HIGH = 2'd1, // between the opening rise and the fall.
		MEAS_LOW  = 2'd2  // between the fall and the closing rise.
	} meter_state_t;

endpackage

//--- hw/uart_frame_pkg.sv
// definitions shared by the frame builder and the UART transmitter.
package uart_frame_pkg;

	// every frame opens with this byte so a receiver can find frame boundaries.
	localparam logic [7:0] FRAME_HEADER = 8'hA5;

	// clocks per bit, 434 gives 115200 baud from a 50 MHz clock.
	localparam int CLK_DIV_DEFAULT = 434;

	// which part of the frame the builder is sending.
	typedef enum logic [2:0] {
		SLOT_IDLE   = 3'd0, // no frame in progress, a measurement may be taken.
		SLOT_HEADER = 3'd1, // the header byte is on the line.
		SLOT_PERIOD = 3'd2, // period bytes, most significant first.
		SLOT_HIGH   = 3'd3, // high time bytes, most significant first.
		SLOT_CHECK  = 3'd4  // the xor checksum closes the frame.
	} frame_slot_t;

	// states of the 8N1 serializer.
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0, // line held high.
		TX_START = 2'd1, // start bit, line low.
		TX_DATA  = 2'd2, // eight data bits, lsb first.
		TX_STOP  = 2'd3  // stop bit, line high.
	} tx_state_t;

endpackage

//--- hw/pwm_edge_sync.sv
`timescale 1ns/1ps

// brings the asynchronous pwm input into the clk domain and marks its edges.
// both strobes come out three cycles after the input moves, so the
// latency cancels when the meter takes differences between edges.
module pwm_edge_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic pwm_in,
	output logic rise,
	output logic fall
);

	logic sync_1; // first metastability flop.
	logic sync_2; // second metastability flop, safe to use from here on.
	logic sync_d; // sync_2 one cycle late, the reference for the compare.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			sync_d <= 1'b0;
			rise   <= 1'b0;
			fall   <= 1'b0;
		end else begin
			sync_1 <= pwm_in;
			sync_2 <= sync_1;
			sync_d <= sync_2;
			rise   <= sync_2 & ~sync_d; // low to high seen between the two flops.
			fall   <= ~sync_2 & sync_d; // high to low, same latency as rise.
		end
	end

endmodule

//--- hw/pwm_period_meter.sv
`timescale 1ns/1ps

// measures high time and period of the synchronized pwm signal in clock cycles.
// a period runs from one rise strobe to the next, and the closing rise also
// opens the following period, so measurements follow each other without a gap.
module pwm_period_meter #(
	parameter int CNT_W = pwm_meas_pkg::CNT_W_DEFAULT
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             enable,
	input  logic             rise,
	input  logic             fall,
	output logic             meas_valid,
	output logic [CNT_W-1:0] period,
	output logic [CNT_W-1:0] high_time
);

	import pwm_meas_pkg::*;

	meter_state_t     state;
	logic [CNT_W-1:0] cnt;      // cycles since the opening rise, 1 on the cycle after it.
	logic [CNT_W-1:0] high_cnt; // count taken at the fall, held until the period closes.
	logic             cnt_sat;

	assign cnt_sat = &cnt; // the counter cannot go further without wrapping.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= WAIT_RISE;
			cnt        <= '0;
			high_cnt   <= '0;
			meas_valid <= 1'b0;
			period     <= '0;
			high_time  <= '0;
		end else begin
			meas_valid <= 1'b0; // a strobe lasts one cycle only.
			if (!enable) begin
				state <= WAIT_RISE; // drop any open period.
				cnt   <= '0;
			end else begin
				case (state)
					WAIT_RISE: begin
						if (rise) begin // a fall here carries no information and is skipped.
							state <= MEAS_HIGH;
							cnt   <= CNT_W'(1);
						end
					end
					MEAS_HIGH: begin
						if (cnt_sat) begin
							state <= WAIT_RISE; // high phase too long to measure.
						end else if (fall) begin
							high_cnt <= cnt; // cnt equals the high cycles at this point.
							cnt      <= cnt + 1'b1;
							state    <= MEAS_LOW;
						end else if (rise) begin
							// a rise with no fall before it means a lost edge.
							// the old period is useless, so this rise opens a new one.
							cnt <= CNT_W'(1);
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					MEAS_LOW: begin
						if (cnt_sat) begin
							state <= WAIT_RISE; // period too long, abort without a strobe.
						end else if (rise) begin
							period     <= cnt; // full period from rise to rise.
							high_time  <= high_cnt;
							meas_valid <= 1'b1;
							cnt        <= CNT_W'(1); // this rise opens the next period.
							state      <= MEAS_HIGH;
						end else begin
							cnt <= cnt + 1'b1; // a second fall cannot occur before a rise.
						end
					end
					default: state <= WAIT_RISE;
				endcase
			end
		end
	end

endmodule

//--- hw/meas_frame_builder.sv
`timescale 1ns/1ps

// turns one measurement into a byte frame for the UART.
// layout is header, period msb first, high time msb first, then the xor of
// all payload bytes. the next byte is requested the cycle after byte_done.
module meas_frame_builder #(
	parameter int CNT_W = pwm_meas_pkg::CNT_W_DEFAULT
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             meas_valid,
	input  logic [CNT_W-1:0] period,
	input  logic [CNT_W-1:0] high_time,
	input  logic             byte_done,
	output logic             byte_start,
	output logic [7:0]       tx_byte
);

	import uart_frame_pkg::*;

	localparam int NB    = CNT_W / 8;      // bytes per value.
	localparam int IDX_W = $clog2(NB + 1); // wide enough to hold NB itself.

	frame_slot_t      slot;
	frame_slot_t      slot_nxt;
	logic [IDX_W-1:0] byte_idx;   // bytes already sent in the current payload slot.
	logic             last_byte;  // the slot has sent all of its bytes.
	logic             send;       // a byte goes out on the next cycle.
	logic [CNT_W-1:0] period_sr;  // period copy, top byte is the next to go.
	logic [CNT_W-1:0] high_sr;    // high time copy, same order.
	logic [7:0]       chk;        // running xor of the payload bytes.
	logic [7:0]       next_byte;

	assign last_byte = (byte_idx == IDX_W'(NB));

	// decide the next slot and whether a byte is sent.
	always_comb begin
		slot_nxt = slot;
		send     = 1'b0;
		case (slot)
			SLOT_IDLE: begin
				if (meas_valid) begin // only taken when no frame is running.
					slot_nxt = SLOT_HEADER;
					send     = 1'b1;
				end
			end
			SLOT_HEADER: begin
				if (byte_done) begin
					slot_nxt = SLOT_PERIOD;
					send     = 1'b1;
				end
			end
			SLOT_PERIOD: begin
				if (byte_done) begin
					slot_nxt = last_byte ? SLOT_HIGH : SLOT_PERIOD;
					send     = 1'b1;
				end
			end
			SLOT_HIGH: begin
				if (byte_done) begin
					slot_nxt = last_byte ? SLOT_CHECK : SLOT_HIGH;
					send     = 1'b1;
				end
			end
			SLOT_CHECK: begin
				if (byte_done) slot_nxt = SLOT_IDLE; // frame complete.
			end
			default: slot_nxt = SLOT_IDLE;
		endcase
	end

	// pick the byte that belongs to the slot being entered.
	always_comb begin
		case (slot_nxt)
			SLOT_HEADER: next_byte = FRAME_HEADER;
			SLOT_PERIOD: next_byte = period_sr[CNT_W-1 -: 8];
			SLOT_HIGH:   next_byte = high_sr[CNT_W-1 -: 8];
			default:     next_byte = chk; // checksum slot, every payload byte is folded in.
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot       <= SLOT_IDLE;
			byte_idx   <= '0;
			byte_start <= 1'b0;
		end else begin
			slot       <= slot_nxt;
			byte_start <= send;
			if (send) begin
				// entering a payload slot restarts the count at the first byte.
				byte_idx <= (slot_nxt != slot) ? IDX_W'(1) : byte_idx + 1'b1;
			end
		end
	end

	// payload path, loaded at the header and shifted byte by byte.
	always_ff @(posedge clk) begin
		if (send) tx_byte <= next_byte;
		if (slot == SLOT_IDLE && meas_valid) begin
			period_sr <= period;
			high_sr   <= high_time;
			chk       <= 8'h00;
		end else if (send && slot_nxt == SLOT_PERIOD) begin
			period_sr <= period_sr << 8;
			chk       <= chk ^ period_sr[CNT_W-1 -: 8];
		end else if (send && slot_nxt == SLOT_HIGH) begin
			high_sr <= high_sr << 8;
			chk     <= chk ^ high_sr[CNT_W-1 -: 8];
		end
	end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

// 8N1 serializer. every bit lasts CLK_DIV cycles and the start bit appears
// on the cycle after byte_start. requests while busy are ignored.
module uart_tx #(
	parameter int CLK_DIV = uart_frame_pkg::CLK_DIV_DEFAULT
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       byte_start,
	input  logic [7:0] tx_byte,
	output logic       txd,
	output logic       tx_busy,
	output logic       byte_done
);

	import uart_frame_pkg::*;

	localparam int DIV_W = $clog2(CLK_DIV + 1);

	tx_state_t        state;
	logic [DIV_W-1:0] div_cnt; // cycles spent in the current bit.
	logic [2:0]       bit_idx; // data bit on the line.
	logic [7:0]       shreg;   // lsb is the next data bit.
	logic             bit_end;
	logic             load;

	assign bit_end = (div_cnt == DIV_W'(CLK_DIV - 1)); // last cycle of a bit.
	assign load    = byte_start && (state == TX_IDLE);
	// busy spans the request cycle through the done cycle, so it stays high between bytes.
	assign tx_busy = (state != TX_IDLE) || byte_start || byte_done;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= TX_IDLE;
			div_cnt   <= '0;
			bit_idx   <= '0;
			txd       <= 1'b1; // idle line is high.
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			div_cnt   <= (state == TX_IDLE || bit_end) ? '0 : div_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					if (load) begin
						state <= TX_START;
						txd   <= 1'b0; // start bit.
					end
				end
				TX_START: begin
					if (bit_end) begin
						state   <= TX_DATA;
						bit_idx <= 3'd0;
						txd     <= shreg[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							state <= TX_STOP;
							txd   <= 1'b1; // stop bit.
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd     <= shreg[0];
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state     <= TX_IDLE;
						byte_done <= 1'b1; // stop bit complete, the line stays high.
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// data copy, taken at the request so the builder may change tx_byte.
	always_ff @(posedge clk) begin
		if (load) begin
			shreg <= tx_byte;
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shreg <= shreg >> 1; // shreg[0] has just been put on the line.
		end
	end

endmodule

//--- hw/pwm_capture_top.sv
`timescale 1ns/1ps

// pwm measurement subsystem. the input goes through the edge synchronizer
// into the meter, and each measurement is framed and sent over txd.
module pwm_capture_top #(
	parameter int CNT_W   = pwm_meas_pkg::CNT_W_DEFAULT,
	parameter int CLK_DIV = uart_frame_pkg::CLK_DIV_DEFAULT
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             enable,
	input  logic             pwm_in,
	output logic             txd,
	output logic             tx_busy,
	output logic             meas_valid,
	output logic [CNT_W-1:0] period,
	output logic [CNT_W-1:0] high_time
);

	logic       rise;       // synchronized edge strobes.
	logic       fall;
	logic       byte_start; // builder asks for a byte.
	logic [7:0] tx_byte;
	logic       byte_done;  // transmitter finished the stop bit.

	pwm_edge_sync pwm_edge_sync_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.pwm_in (pwm_in),
		.rise   (rise),
		.fall   (fall)
	);

	pwm_period_meter #(.CNT_W(CNT_W)) pwm_period_meter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.rise       (rise),
		.fall       (fall),
		.meas_valid (meas_valid),
		.period     (period),
		.high_time  (high_time)
	);

	meas_frame_builder #(.CNT_W(CNT_W)) meas_frame_builder_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.meas_valid (meas_valid),
		.period     (period),
		.high_time  (high_time),
		.byte_done  (byte_done),
		.byte_start (byte_start),
		.tx_byte    (tx_byte)
	);

	uart_tx #(.CLK_DIV(CLK_DIV)) uart_tx_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_start (byte_start),
		.tx_byte    (tx_byte),
		.txd        (txd),
		.tx_busy    (tx_busy),
		.byte_done  (byte_done)
	);

endmodule

//--- verification/pwm_capture_sva.sv
`timescale 1ns/1ps

// protocol checks on the capture top level.
module pwm_capture_sva #(
	parameter int CNT_W   = pwm_meas_pkg::CNT_W_DEFAULT,
	parameter int CLK_DIV = uart_frame_pkg::CLK_DIV_DEFAULT
) (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      meas_valid,
	input logic [CNT_W-1:0]          period,
	input logic [CNT_W-1:0]          high_time,
	input logic                      txd,
	input logic                      tx_busy,
	input uart_frame_pkg::tx_state_t tx_state
);

	import uart_frame_pkg::*;

	// a measurement strobe never lasts longer than one cycle.
	valid_single: assert property (@(posedge clk) disable iff (!rst_n)
		meas_valid |=> !meas_valid)
		else $error("meas_valid stayed high for more than one cycle");

	// the high phase is always part of the period it was measured in.
	valid_values: assert property (@(posedge clk) disable iff (!rst_n)
		meas_valid |-> (high_time < period))
		else $error("high_time %h not below period %h at meas_valid", high_time, period);

	assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> txd)
		else $error("txd low while the transmitter is idle");

	// busy drops the cycle after byte_done, once a stop bit has run exactly CLK_DIV cycles.
	busy_end: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(tx_busy) |-> txd && ($past(tx_state, 2) == TX_STOP)
			&& ($past(tx_state, CLK_DIV + 1) == TX_STOP)
			&& ($past(tx_state, CLK_DIV + 2) == TX_DATA))
		else $error("tx_busy fell outside the end of a stop bit");

endmodule

bind pwm_capture_top pwm_capture_sva #(.CNT_W(CNT_W), .CLK_DIV(CLK_DIV)) pwm_capture_sva_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.meas_valid  (meas_valid),
	.period      (period),
	.high_time   (high_time),
	.txd         (txd),
	.tx_busy     (tx_busy),
	.tx_state    (uart_tx_i.state)
);

//--- verification/pwm_capture_tb.sv
`timescale 1ns/1ps

module pwm_capture_tb;

	import uart_frame_pkg::*;

	localparam int CNT_W     = 16;
	localparam int CLK_DIV   = 8;
	localparam int NB        = CNT_W / 8;      // bytes per value.
	localparam int NBYTES    = 2 * NB + 2;     // header, both values and the checksum.
	localparam int FRAME_CYC = NBYTES * (10 * CLK_DIV + 2);
	localparam int N_FIXED   = 20;
	localparam int N_RAND    = 12;
	localparam int N_DROP    = 60;
	localparam int N_FLAT    = 150;
	localparam int N_OFF     = 10;
	localparam int PULSE_CYC = N_FIXED * 40 + N_RAND * 121 + N_DROP * 14 + 2 * N_FLAT + N_OFF * 16;
	localparam int LIMIT     = PULSE_CYC * 3 / 2 + (N_RAND + 4) * FRAME_CYC;

	logic             clk;
	logic             rst_n;
	logic             enable;
	logic             pwm_in;
	logic             txd;
	logic             tx_busy;
	logic             meas_valid;
	logic [CNT_W-1:0] period;
	logic [CNT_W-1:0] high_time;

	int                 cyc = 0;         // rising clock edges since time zero.
	int                 value_errs = 0;
	int                 other_errs = 0;
	integer             seed;
	int                 hi;
	int                 lo;
	bit                 quiet = 1'b0;    // neither a strobe nor a frame may appear.
	bit                 open_period = 1'b0; // a rise was driven while the meter was enabled.
	bit                 fall_seen = 1'b0;
	int                 rise_cyc;
	int                 fall_cyc;
	int                 accepted = 0;    // strobes that found the transmitter idle.
	int                 frames = 0;
	bit                 rx_active = 1'b0;
	logic [7:0]         rx_frame [NBYTES];
	logic [2*CNT_W-1:0] meas_q [$];      // {period, high} per completed driven period.
	logic [2*CNT_W-1:0] frame_q [$];     // measurements that should come out as frames.
	logic [2*CNT_W-1:0] mv_exp;

	pwm_capture_top #(.CNT_W(CNT_W), .CLK_DIV(CLK_DIV)) pwm_capture_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.enable     (enable),
		.pwm_in     (pwm_in),
		.txd        (txd),
		.tx_busy    (tx_busy),
		.meas_valid (meas_valid),
		.period     (period),
		.high_time  (high_time)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic value_mismatch(input string name, input logic [31:0] want, input logic [31:0] got);
		value_errs++;
		$display("ERROR %s expected %h got %h", name, want, got);
	endtask

	// holds the pwm input at v for the given cycles and notes each period the meter should report.
	task automatic set_pwm(input logic v, input int cycles);
		@(negedge clk);
		if (v && !pwm_in) begin
			if (open_period && fall_seen) begin
				meas_q.push_back({CNT_W'(cyc - rise_cyc), CNT_W'(fall_cyc - rise_cyc)});
			end
			open_period = enable;
			fall_seen   = 1'b0;
			rise_cyc    = cyc;
		end else if (!v && pwm_in) begin
			fall_cyc  = cyc;
			fall_seen = 1'b1;
		end
		pwm_in = v;
		repeat (cycles - 1) @(negedge clk);
	endtask

	task automatic pulse(input int high_cycles, input int low_cycles);
		set_pwm(1'b1, high_cycles);
		set_pwm(1'b0, low_cycles);
	endtask

	// waits until every expected strobe and frame has come out and the line is idle.
	task automatic wait_idle();
		@(posedge clk);
		while (meas_q.size() != 0 || frame_q.size() != 0 || tx_busy || rx_active) @(posedge clk);
	endtask

	// a short disable puts the meter back in WAIT_RISE with the input low.
	task automatic restart_meter();
		@(negedge clk);
		enable      = 1'b0;
		open_period = 1'b0;
		repeat (2) @(negedge clk);
		pwm_in = 1'b0;
		repeat (6) @(negedge clk);
		enable = 1'b1;
		repeat (2) @(negedge clk);
	endtask

	function automatic frame_slot_t slot_of(input int idx);
		if (idx == 0) return SLOT_HEADER;
		if (idx <= NB) return SLOT_PERIOD;
		if (idx <= 2 * NB) return SLOT_HIGH;
		return SLOT_CHECK;
	endfunction

	// compares a decoded frame with the measurement that started it.
	task automatic check_frame();
		logic [2*CNT_W-1:0] m;
		logic [7:0]         want;
		logic [7:0]         chk;
		frame_slot_t        slot;
		frames++;
		assert (frame_q.size() != 0) else begin
			other_errs++;
			$display("a frame was sent while no accepted measurement was waiting for it");
		end
		if (frame_q.size() != 0) begin
			m   = frame_q.pop_front();
			chk = 8'h00;
			for (int i = 0; i < NBYTES; i++) begin
				slot = slot_of(i);
				case (slot)
					SLOT_HEADER: want = FRAME_HEADER;
					SLOT_CHECK:  want = chk;
					default:     want = m[2*CNT_W-1-8*(i-1) -: 8]; // payload is {period, high}, msb first.
				endcase
				if (slot == SLOT_PERIOD || slot == SLOT_HIGH) chk = chk ^ want;
				assert (rx_frame[i] == want) else
					value_mismatch($sformatf("txd byte %0d", i), 32'(want), 32'(rx_frame[i]));
			end
		end
	endtask

	// measurement monitor, outputs are stable at the falling edge.
	always @(negedge clk) begin
		if (rst_n && meas_valid) begin
			assert (!quiet) else begin
				other_errs++;
				$display("meas_valid strobe while the input was flat or the meter disabled");
			end
			assert (meas_q.size() != 0) else begin
				other_errs++;
				$display("meas_valid strobe with no completed pwm period behind it");
			end
			if (meas_q.size() != 0) begin
				mv_exp = meas_q.pop_front();
				assert (period == mv_exp[2*CNT_W-1:CNT_W]) else
					value_mismatch("period", 32'(mv_exp[2*CNT_W-1:CNT_W]), 32'(period));
				assert (high_time == mv_exp[CNT_W-1:0]) else
					value_mismatch("high_time", 32'(mv_exp[CNT_W-1:0]), 32'(high_time));
				if (!tx_busy) begin // only an idle transmitter starts a frame.
					frame_q.push_back(mv_exp);
					accepted++;
				end
			end
		end
		if (rst_n && quiet) assert (txd) else value_mismatch("txd", 32'h1, 32'(txd));
	end

	// UART receiver, samples each bit in its middle.
	initial begin : uart_rx
		logic [7:0] rx_byte;
		int         nrx;
		nrx = 0;
		forever begin
			@(negedge clk);
			if (rst_n && !txd) begin
				rx_active = 1'b1;
				repeat (CLK_DIV / 2) @(negedge clk); // middle of the start bit.
				for (int i = 0; i < 8; i++) begin
					repeat (CLK_DIV) @(negedge clk);
					rx_byte[i] = txd;
				end
				repeat (CLK_DIV) @(negedge clk);
				assert (txd) else begin
					other_errs++;
					$display("stop bit of frame byte %0d was low", nrx);
				end
				rx_frame[nrx] = rx_byte;
				nrx++;
				if (nrx == NBYTES) begin
					check_frame();
					nrx = 0;
				end
				rx_active = 1'b0;
			end
		end
	end

	initial begin
		seed   = 32'h07b825fb;
		rst_n  = 1'b0;
		enable = 1'b0;
		pwm_in = 1'b0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (txd === 1'b1) else value_mismatch("txd", 32'h1, 32'(txd));
		assert (meas_valid === 1'b0) else value_mismatch("meas_valid", 32'h0, 32'(meas_valid));
		assert (tx_busy === 1'b0) else value_mismatch("tx_busy", 32'h0, 32'(tx_busy));
		enable = 1'b1;
		repeat (4) @(negedge clk);
		for (int i = 0; i < N_FIXED; i++) pulse(13, 27);
		wait_idle();
		restart_meter();
		// one period per pattern, closed by a rise that is then held through the frame.
		for (int i = 0; i < N_RAND; i++) begin
			hi = 1 + int'({$random(seed)} % 60);
			lo = 1 + int'({$random(seed)} % 60);
			pulse(hi, lo);
			set_pwm(1'b1, 1);
			wait_idle();
			restart_meter();
		end
		for (int i = 0; i < N_DROP; i++) pulse(5, 9); // strobes every 14 cycles, most dropped.
		wait_idle();
		restart_meter();
		assert (frames == accepted) else value_mismatch("frame count", 32'(accepted), 32'(frames));
		quiet = 1'b1;
		set_pwm(1'b0, N_FLAT);
		set_pwm(1'b1, N_FLAT);
		@(negedge clk);
		enable      = 1'b0;
		open_period = 1'b0;
		for (int i = 0; i < N_OFF; i++) pulse(7, 9);
		set_pwm(1'b0, 8);
		quiet = 1'b0;
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
hw/pwm_meas_pkg.sv
hw/uart_frame_pkg.sv
hw/pwm_edge_sync.sv
hw/pwm_period_meter.sv
hw/meas_frame_builder.sv
hw/uart_tx.sv
hw/pwm_capture_top.sv
verification/pwm_capture_sva.sv
verification/pwm_capture_tb.sv

//--- Makefile
TOP = pwm_capture_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and look for the pass line"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
